//--- golomb_parser.f
+incdir+verification
verilog/golomb_pkg.sv
verilog/golomb_ifs.sv
verilog/apb_stream_port.sv
verilog/bit_window.sv
verilog/golomb_decoder.sv
verilog/result_fifo.sv
verilog/golomb_parser_top.sv
verification/tb_golomb_parser.sv

//--- verification/tb_golomb_model.svh
`ifndef TB_GOLOMB_MODEL_SVH
`define TB_GOLOMB_MODEL_SVH

// ==================================================
// Random source and stream model
// ==================================================
logic [15:0] lfsr_state = 16'd24;
bit          stream_q[$]; // Encoded bits not yet pushed.
logic [31:0] cmd_q[$];
int          len_q[$];
logic [31:0] exp_q[$];

// Galois form with taps at 16 14 13 11.
function automatic logic lfsr_step();
	logic out;
	out = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (out)
		lfsr_state = lfsr_state ^ 16'hB400;
	return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[30:0], lfsr_step()};
	return v;
endfunction

function automatic void push_bits(input logic [31:0] v, input int n);
	for (int i = n - 1; i >= 0; i--)
		stream_q.push_back(v[i]);
endfunction

function automatic logic [31:0] next_word();
	logic [31:0] w;
	for (int i = 0; i < 32; i++)
		w[31-i] = stream_q[i];
	return w;
endfunction

function automatic void queue_cmd(input logic [1:0] kind, input int nbits, input int len,
	input logic [31:0] expected);
	cmd_q.push_back((32'(nbits) << NBITS_LSB) | 32'(kind));
	len_q.push_back(len);
	exp_q.push_back(expected);
endfunction

// Prefix of lz zeros, then codeNum+1 in lz+1 bits.
function automatic int encode_golomb(input logic [31:0] code);
	logic [31:0] v;
	int          lz;
	v = code + 1;
	lz = 0;
	for (int i = 0; i < 32; i++)
		if (v[i])
			lz = i;
	push_bits('0, lz);
	push_bits(v, lz + 1);
	return 2 * lz + 1;
endfunction

function automatic void add_ue(input logic [31:0] code);
	queue_cmd(KIND_UE, 0, encode_golomb(code), code);
endfunction

function automatic void add_se(input int val);
	int code;
	code = (val > 0) ? 2 * val - 1 : -2 * val;
	queue_cmd(KIND_SE, 0, encode_golomb(code), val);
endfunction

function automatic void add_u(input int n, input logic [31:0] v, input logic [1:0] kind,
	input int field);
	push_bits(v, n);
	queue_cmd(kind, field, n, v);
endfunction

function automatic void pad_stream();
	while (stream_q.size() % 32 != 0)
		stream_q.push_back(1'b0);
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
	input string what);
	if (got !== expected) begin
		$display("[FAIL] %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, expected);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at the first mismatch.");
	end
endtask

`endif

//--- verification/tb_golomb_parser.sv
`timescale 1ns/1ns

module tb_golomb_parser;
	import golomb_pkg::*;

	localparam int N_UE  = 200;
	localparam int N_MIX = 150;
	localparam int N_CMDS = N_UE + N_MIX + 10 + 6 + 1 + 4; // Padding drains too.
	localparam int WATCHDOG_CYCLES = 400 * N_CMDS + 1000;

	logic              clk = 1'b0;
	logic              i_arst_n = 1'b0;
	logic              i_psel = 1'b0;
	logic              i_penable = 1'b0;
	logic              i_pwrite = 1'b0;
	logic [ADDR_W-1:0] i_paddr = '0;
	logic [WORD_W-1:0] i_pwdata = '0;
	logic [WORD_W-1:0] o_prdata;
	logic              o_pready;
	logic              o_pslverr;
	int                win_bits = 0; // Bits the DUT window should hold.

	`include "tb_golomb_model.svh"

	golomb_parser_top dut0 (
		.clk(clk), .i_arst_n(i_arst_n), .i_psel(i_psel), .i_penable(i_penable),
		.i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr)
	);

	always #2 clk = ~clk;

	// ==================================================
	// APB driver
	// ==================================================
	// Negative limit waits as long as it takes.
	task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] wdata, input int limit,
		output logic [WORD_W-1:0] rdata, output logic err, output logic done);
		int waited;
		waited = 0;
		@(posedge clk);
		i_psel    <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite  <= wr;
		i_paddr   <= addr;
		i_pwdata  <= wdata;
		@(posedge clk);
		i_penable <= 1'b1;
		@(negedge clk);
		while (!o_pready && (limit < 0 || waited < limit)) begin
			waited++;
			@(negedge clk);
		end
		done  = o_pready;
		rdata = o_prdata;
		err   = o_pslverr;
		@(posedge clk);
		i_psel    <= 1'b0; // Also withdraws a stalled access.
		i_penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		logic [WORD_W-1:0] rd;
		logic              err;
		logic              done;
		apb_access(1'b1, addr, data, -1, rd, err, done);
		check_value(err, 0, "write slave error");
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] rd,
		output logic err);
		logic done;
		apb_access(1'b0, addr, '0, -1, rd, err, done);
	endtask

	task automatic push_word();
		write_reg(ADDR_STREAM, next_word());
		repeat (WORD_W) void'(stream_q.pop_front());
		win_bits += WORD_W;
	endtask

	task automatic post_cmd();
		int len;
		len = len_q.pop_front();
		while (win_bits < len)
			push_word();
		write_reg(ADDR_CMD, cmd_q.pop_front());
		win_bits -= len;
	endtask

	task automatic wait_count(input int n);
		logic [WORD_W-1:0] st;
		logic              err;
		st = '0;
		while (st[CNT_W-1:0] < n)
			read_reg(ADDR_STATUS, st, err);
	endtask

	task automatic read_check(input string what);
		logic [WORD_W-1:0] d;
		logic              err;
		wait_count(1);
		read_reg(ADDR_RESULT, d, err);
		check_value(err, 0, {what, ", slave error"});
		check_value(d, exp_q.pop_front(), what);
	endtask

	// Leftover window bits are zero padding.
	task automatic drain_window();
		int n;
		while (win_bits > 0) begin
			n = (win_bits > 16) ? 16 : win_bits;
			queue_cmd(KIND_U, n, n, '0);
			post_cmd();
			read_check("drained padding");
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		logic [WORD_W-1:0] rd;
		logic              err;
		logic              done;
		logic [1:0]        kind;
		logic              neg;
		logic [31:0]       val;
		int                n;
		int                mag;
		int                field;

		repeat (3) @(posedge clk);
		i_arst_n <= 1'b1;

		read_reg(ADDR_STATUS, rd, err);
		check_value(rd, '0, "status after reset");
		read_reg(ADDR_RESULT, rd, err);
		check_value(err, 1, "empty FIFO read error");
		check_value(rd, '0, "empty FIFO read data");

		// One stream with ue(v) first and then all kinds mixed.
		for (int i = 0; i < N_UE; i++)
			add_ue(rand_bits(rand_bits(4)));
		for (int i = 0; i < N_MIX; i++) begin
			kind = 2'(rand_bits(2));
			if (kind == 2'd0) begin
				add_ue(rand_bits(rand_bits(4)));
			end else if (kind == 2'd1) begin
				mag = rand_bits(rand_bits(4)) >> 1;
				neg = rand_bits(1);
				add_se(neg ? -mag : mag + 1);
			end else begin
				n     = int'(rand_bits(4)) + 1;
				val   = rand_bits(n);
				field = (n == 16 && rand_bits(1)) ? 0 : n; // Zero also means 16.
				add_u(n, val, kind, field);
			end
		end
		pad_stream();
		for (int i = 0; i < N_UE + N_MIX; i++) begin
			post_cmd();
			read_check(i < N_UE ? "ue(v) result" : "mixed result");
		end
		read_reg(ADDR_STATUS, rd, err);
		check_value(rd[STAT_FILL_LSB +: FILL_W], win_bits, "window fill after stream");
		drain_window();

		// Full FIFO holds the ninth command, so the tenth CMD write stalls.
		for (int i = 0; i < 10; i++) begin
			if (i % 2 == 0)
				add_ue(rand_bits(1));
			else
				add_u(3, rand_bits(3), KIND_U, 3);
		end
		pad_stream();
		for (int i = 0; i < 9; i++)
			post_cmd();
		wait_count(FIFO_DEPTH);
		read_reg(ADDR_STATUS, rd, err);
		check_value(rd[STAT_PEND_BIT], 1, "command held on a full FIFO");
		apb_access(1'b1, ADDR_CMD, cmd_q[0], 20, rd, err, done);
		check_value(done, 0, "CMD write completed while a command was held");
		read_check("result under back-pressure");
		post_cmd();
		for (int i = 0; i < 9; i++)
			read_check("result under back-pressure");
		drain_window();

		// Two words fill the window and the third waits for 32 bits to go.
		for (int i = 0; i < 6; i++)
			add_u(16, rand_bits(16), KIND_U, 16);
		push_word();
		push_word();
		apb_access(1'b1, ADDR_STREAM, next_word(), 20, rd, err, done);
		check_value(done, 0, "STREAM write completed on a full window");
		post_cmd();
		post_cmd();
		push_word();
		for (int i = 0; i < 4; i++)
			post_cmd();
		for (int i = 0; i < 6; i++)
			read_check("u(16) after window stall");

		// An all zero word has no leading one within range.
		write_reg(ADDR_STREAM, '0);
		win_bits += WORD_W;
		write_reg(ADDR_CMD, 32'(KIND_UE));
		rd = 32'h1 << STAT_PEND_BIT;
		while (rd[STAT_PEND_BIT])
			read_reg(ADDR_STATUS, rd, err);
		check_value(rd[STAT_ERR_BIT], 1, "sticky error flag");
		check_value(rd[CNT_W-1:0], 0, "result count after a bad code");
		check_value(rd[STAT_FILL_LSB +: FILL_W], win_bits, "window fill after a bad code");

		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles.", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired.");
	end

endmodule

//--- verilog/apb_stream_port.sv
`timescale 1ns/1ns

module apb_stream_port (
	input  logic                          clk,
	input  logic                          i_arst_n,
	input  logic                          i_psel,
	input  logic                          i_penable,
	input  logic                          i_pwrite,
	input  logic [golomb_pkg::ADDR_W-1:0] i_paddr,
	input  logic [golomb_pkg::WORD_W-1:0] i_pwdata,
	input  logic                          i_win_room,
	input  logic [golomb_pkg::WORD_W-1:0] i_fifo_data,
	input  logic                          i_fifo_empty,
	input  logic [golomb_pkg::CNT_W-1:0]  i_fifo_count,
	input  logic [golomb_pkg::FILL_W-1:0] i_win_fill,
	input  logic                          i_dec_error,
	cmd_if.host                           cmd,
	output logic [golomb_pkg::WORD_W-1:0] o_prdata,
	output logic                          o_pready,
	output logic                          o_pslverr,
	output logic                          o_win_push,
	output logic [golomb_pkg::WORD_W-1:0] o_win_word,
	output logic                          o_fifo_pop
);
	import golomb_pkg::*;

	logic              in_xfer; // Setup phase seen, transfer still open.
	logic              access;
	logic              sel_stream;
	logic              sel_cmd;
	logic              sel_result;
	logic              sel_status;
	logic              can_finish;
	logic              done;
	logic [WORD_W-1:0] status_word;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			in_xfer <= 1'b0;
		else if (i_psel && !i_penable)
			in_xfer <= 1'b1;
		else if (done)
			in_xfer <= 1'b0;
	end

	assign access     = i_psel && i_penable && in_xfer;
	assign sel_stream = (i_paddr == ADDR_STREAM);
	assign sel_cmd    = (i_paddr == ADDR_CMD);
	assign sel_result = (i_paddr == ADDR_RESULT);
	assign sel_status = (i_paddr == ADDR_STATUS);

	// Only stream pushes and command posts can stall.
	always_comb begin
		can_finish = 1'b1;
		if (i_pwrite && sel_stream)
			can_finish = i_win_room;
		else if (i_pwrite && sel_cmd)
			can_finish = cmd.ready;
	end

	assign done     = access && can_finish;
	assign o_pready = done;

	always_comb begin
		status_word = '0;
		status_word[CNT_W-1:0] = i_fifo_count;
		status_word[STAT_FILL_LSB +: FILL_W] = i_win_fill;
		status_word[STAT_PEND_BIT] = !cmd.ready; // Command pending.
		status_word[STAT_ERR_BIT]  = i_dec_error;
	end

	// Unmapped reads and an empty RESULT return zero.
	always_comb begin
		o_prdata = '0;
		if (access && !i_pwrite) begin
			if (sel_result && !i_fifo_empty)
				o_prdata = i_fifo_data;
			else if (sel_status)
				o_prdata = status_word;
		end
	end

	assign o_pslverr = access && !i_pwrite && sel_result && i_fifo_empty;

	// Strobes fire in the completing cycle only.
	assign o_win_push = done && i_pwrite && sel_stream;
	assign o_win_word = i_pwdata;
	assign cmd.valid  = done && i_pwrite && sel_cmd;
	assign cmd.kind   = i_pwdata[KIND_LSB +: KIND_W];
	assign cmd.nbits  = i_pwdata[NBITS_LSB +: NBITS_W];
	assign o_fifo_pop = done && !i_pwrite && sel_result && !i_fifo_empty;

endmodule

//--- verilog/bit_window.sv
`timescale 1ns/1ns

module bit_window (
	input  logic                          clk,
	input  logic                          i_arst_n,
	input  logic                          i_push,
	input  logic [golomb_pkg::WORD_W-1:0] i_word,
	output logic                          o_room,
	window_if.source                      win
);
	import golomb_pkg::*;

	logic [WIN_W-1:0]  bits_q; // Oldest bit at the top.
	logic [FILL_W-1:0] fill_q;
	logic [WIN_W-1:0]  kept;
	logic [FILL_W-1:0] kept_fill;
	logic [WIN_W-1:0]  new_word;
	logic [WIN_W-1:0]  bits_d;
	logic [FILL_W-1:0] fill_d;

	// Drop the consumed bits first, then append below what is left.
	always_comb begin
		kept      = bits_q;
		kept_fill = fill_q;
		if (win.consume) begin
			kept      = bits_q << win.consume_len;
			kept_fill = fill_q - FILL_W'(win.consume_len);
		end

		new_word = {i_word, {(WIN_W-WORD_W){1'b0}}} >> kept_fill;

		bits_d = kept;
		fill_d = kept_fill;
		if (i_push) begin
			bits_d = kept | new_word; // Bits below fill are always zero.
			fill_d = kept_fill + FILL_W'(WORD_W);
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			bits_q <= '0;
			fill_q <= '0;
		end else begin
			bits_q <= bits_d;
			fill_q <= fill_d;
		end
	end

	// Room for one more word.
	assign o_room = (fill_q <= FILL_W'(WIN_W - WORD_W));

	assign win.peek = bits_q[WIN_W-1 -: PEEK_W];
	assign win.fill = fill_q;

endmodule

//--- verilog/golomb_decoder.sv
`timescale 1ns/1ns

module golomb_decoder (
	input  logic                          clk,
	input  logic                          i_arst_n,
	input  logic                          i_fifo_full,
	cmd_if.parser                         cmd,
	window_if.sink                        win,
	output logic                          o_res_push,
	output logic [golomb_pkg::WORD_W-1:0] o_res_data,
	output logic                          o_error
);
	import golomb_pkg::*;

	logic               pending_q;
	logic [KIND_W-1:0]  kind_q;
	logic [NBITS_W-1:0] nbits_q;
	logic               error_q;

	logic               is_fixed;
	logic               one_found;
	logic [LZ_W-1:0]    lead_zeros;
	logic [LEN_W-1:0]   fixed_len;
	logic [LEN_W-1:0]   need_len;
	logic [PEEK_W-1:0]  code_field;
	logic [WORD_W-1:0]  code_num;
	logic [WORD_W-1:0]  se_val;
	logic               no_one;
	logic               fire;

	// ==================================================
	// Command register
	// ==================================================
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pending_q <= 1'b0;
			error_q   <= 1'b0;
		end else begin
			if (cmd.valid && cmd.ready)
				pending_q <= 1'b1;
			else if (fire || (pending_q && no_one))
				pending_q <= 1'b0;

			if (pending_q && no_one)
				error_q <= 1'b1; // Sticky until reset.
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.valid && cmd.ready) begin
			kind_q  <= cmd.kind;
			nbits_q <= cmd.nbits;
		end
	end

	assign cmd.ready = !pending_q;

	// ==================================================
	// Heading one detection and decode
	// ==================================================
	// Last hit wins, so the topmost one sets the count.
	always_comb begin
		one_found  = 1'b0;
		lead_zeros = '0;
		for (int i = MAX_LZ; i >= 0; i--) begin
			if (win.peek[PEEK_W-1-i]) begin
				one_found  = 1'b1;
				lead_zeros = LZ_W'(i);
			end
		end
	end

	assign is_fixed  = (kind_q >= KIND_U);
	assign fixed_len = (nbits_q == '0 || nbits_q > NBITS_W'(U_MAX_N)) ?
		LEN_W'(U_MAX_N) : LEN_W'(nbits_q);
	assign need_len  = is_fixed ? fixed_len : LEN_W'({lead_zeros, 1'b1}); // 2*lz+1.

	// The whole Exp-Golomb field read as a number is codeNum+1.
	assign code_field = win.peek >> (PEEK_W - need_len);
	assign code_num   = code_field - 1'b1;
	assign se_val     = code_num[0] ? (code_num + 1'b1) >> 1 : ~(code_num >> 1) + 1'b1;

	always_comb begin
		case (kind_q)
			KIND_UE: o_res_data = code_num;
			KIND_SE: o_res_data = se_val;
			default: o_res_data = code_field; // u(n), top n bits.
		endcase
	end

	// No one in range while enough bits are present.
	assign no_one = !is_fixed && !one_found && (win.fill >= FILL_W'(MAX_LZ + 1));

	assign fire = pending_q && (is_fixed || one_found) &&
		(win.fill >= FILL_W'(need_len)) && !i_fifo_full;

	assign win.consume     = fire;
	assign win.consume_len = need_len;
	assign o_res_push      = fire;
	assign o_error         = error_q;

endmodule

//--- verilog/golomb_ifs.sv
`timescale 1ns/1ns

interface cmd_if;
	import golomb_pkg::*;

	logic [KIND_W-1:0]  kind;
	logic [NBITS_W-1:0] nbits;
	logic               valid; // Completing cycle of a CMD write.
	logic               ready; // No command held.

	modport host (output kind, output nbits, output valid, input ready);
	modport parser (input kind, input nbits, input valid, output ready);
endinterface

interface window_if;
	import golomb_pkg::*;

	logic [PEEK_W-1:0] peek; // Oldest bits, left aligned.
	logic [FILL_W-1:0] fill;
	logic              consume;
	logic [LEN_W-1:0]  consume_len;

	// Bits dropped at the edge after consume.
	modport source (output peek, output fill, input consume, input consume_len);
	modport sink (input peek, input fill, output consume, output consume_len);
endinterface

//--- verilog/golomb_parser_top.sv
`timescale 1ns/1ns

module golomb_parser_top (
	input  logic                          clk,
	input  logic                          i_arst_n,
	input  logic                          i_psel,
	input  logic                          i_penable,
	input  logic                          i_pwrite,
	input  logic [golomb_pkg::ADDR_W-1:0] i_paddr,
	input  logic [golomb_pkg::WORD_W-1:0] i_pwdata,
	output logic [golomb_pkg::WORD_W-1:0] o_prdata,
	output logic                          o_pready,
	output logic                          o_pslverr
);
	import golomb_pkg::*;

	logic              win_room;
	logic              win_push;
	logic [WORD_W-1:0] win_word;

	logic              res_push;
	logic [WORD_W-1:0] res_data;
	logic              dec_error;

	logic              fifo_pop;
	logic [WORD_W-1:0] fifo_data;
	logic              fifo_empty;
	logic              fifo_full;
	logic [CNT_W-1:0]  fifo_count;

	cmd_if    cmd_bus ();
	window_if win_bus ();

	// ==================================================
	// Bus side
	// ==================================================
	apb_stream_port apb_stream_port (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.i_win_room(win_room), .i_win_fill(win_bus.fill),
		.i_fifo_data(fifo_data), .i_fifo_empty(fifo_empty), .i_fifo_count(fifo_count),
		.i_dec_error(dec_error),
		.cmd(cmd_bus.host),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.o_win_push(win_push), .o_win_word(win_word), .o_fifo_pop(fifo_pop)
	);

	// ==================================================
	// Parsing datapath
	// ==================================================
	bit_window bit_window (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_push(win_push), .i_word(win_word),
		.o_room(win_room),
		.win(win_bus.source)
	);

	golomb_decoder golomb_decoder (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_fifo_full(fifo_full),
		.cmd(cmd_bus.parser), .win(win_bus.sink),
		.o_res_push(res_push), .o_res_data(res_data), .o_error(dec_error)
	);

	result_fifo result_fifo (
		.clk(clk), .i_arst_n(i_arst_n),
		.i_push(res_push), .i_data(res_data), .i_pop(fifo_pop),
		.o_data(fifo_data), .o_empty(fifo_empty), .o_full(fifo_full),
		.o_count(fifo_count)
	);

endmodule

//--- verilog/golomb_pkg.sv
package golomb_pkg;

	// ==================================================
	// APB side and register map
	// ==================================================
	localparam int WORD_W = 32;
	localparam int ADDR_W = 4;

	localparam logic [ADDR_W-1:0] ADDR_STREAM = 4'h0; // Write only, pushes a stream word.
	localparam logic [ADDR_W-1:0] ADDR_CMD    = 4'h4; // Write only, posts a command.
	localparam logic [ADDR_W-1:0] ADDR_RESULT = 4'h8; // Read only, pops one result.
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'hC;

	// Command word fields.
	localparam int KIND_W    = 2;
	localparam int KIND_LSB  = 0;
	localparam int NBITS_W   = 5;
	localparam int NBITS_LSB = 4;

	// Status word fields, FIFO count sits at bit 0.
	localparam int STAT_FILL_LSB = 8;
	localparam int STAT_PEND_BIT = 16;
	localparam int STAT_ERR_BIT  = 17;

	localparam logic [KIND_W-1:0] KIND_UE = 2'd0;
	localparam logic [KIND_W-1:0] KIND_SE = 2'd1;
	localparam logic [KIND_W-1:0] KIND_U  = 2'd2; // Code 3 decodes as u(n) too.

	// ==================================================
	// Bit window and decoder
	// ==================================================
	localparam int WIN_W   = 64;
	localparam int PEEK_W  = 32;
	localparam int FILL_W  = 7;
	localparam int LEN_W   = 6;
	localparam int MAX_LZ  = 15;
	localparam int LZ_W    = 4;
	localparam int U_MAX_N = 16; // Longest u(n) element.

	localparam int FIFO_DEPTH = 8;
	localparam int CNT_W      = 4;

endpackage

//--- verilog/result_fifo.sv
`timescale 1ns/1ns

module result_fifo #(
	parameter int DEPTH = golomb_pkg::FIFO_DEPTH
) (
	input  logic                          clk,
	input  logic                          i_arst_n,
	input  logic                          i_push,
	input  logic [golomb_pkg::WORD_W-1:0] i_data,
	input  logic                          i_pop,
	output logic [golomb_pkg::WORD_W-1:0] o_data,
	output logic                          o_empty,
	output logic                          o_full,
	output logic [golomb_pkg::CNT_W-1:0]  o_count
);
	import golomb_pkg::*;

	logic [WORD_W-1:0]        mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [CNT_W-1:0]         count_q;
	logic                     do_push;
	logic                     do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	// Pointers wrap on their own for a power of two depth.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_q <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	assign o_data  = mem[rd_ptr]; // Head entry.
	assign o_empty = (count_q == '0);
	assign o_full  = (count_q == CNT_W'(DEPTH));
	assign o_count = count_q;

endmodule
